//--- files.f
cpc_pkg.sv
cpc_rom_loader.sv
cpc_mf2_ctrl.sv
cpc_mf2_ram.sv
cpc_mem_arbiter.sv
cpc_mem_glue.sv
tb_cpc_mem_glue.sv

//--- Makefile
TOP = tb_cpc_mem_glue

.PHONY: all run build lint clean

all: run

build:
	verilator --binary --timing -j 0 -f files.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module cpc_mem_glue

clean:
	rm -rf obj_dir

//--- tb_cpc_mem_glue.sv
/*
 * Testbench for the CPC memory glue. Downloads system and expansion ROMs
 * under reset, then checks the ROM mask, Multiface entry, register shadow
 * and control port against a model kept here. Random data from a fixed seed.
 */
module tb_cpc_mem_glue;
	import cpc_pkg::*;

	localparam int n_sys        = 24;
	localparam int n_files      = 6;
	localparam int n_file_bytes = 3;
	localparam int n_mf2        = 40;
	localparam int wd_cycles    = (n_sys + 1 + n_files * n_file_bytes) * 70 + n_mf2 * 12 + 2000;

	logic                 clk_sys = 1'b0;
	logic                 reset;
	dl_stream_t           dl;
	logic                 dl_wait;
	cpu_bus_t             cpu;
	logic                 key_nmi;
	mf2_mode_t            mode;
	logic                 model_sel;
	ram_req_t             ram_req;
	logic [7:0]           ram_dout;
	logic [7:0]           cpu_din;
	logic [rom_map_w-1:0] rom_map;
	logic                 nmi;
	logic                 mf2_active;

	integer               seed = 55772;
	integer               r;
	logic [255:0]         map_model = '0;
	logic [7:0]           mf2_model [8192];
	logic [12:0]          written [$];
	logic [7:0]           loaded [$];
	logic [4:0]           pen_m;
	logic [3:0]           crtc_m;

	cpc_mem_glue uut (.*);

	always #20 clk_sys = ~clk_sys;

	// Watchdog, sized from the byte counts
	initial begin
		#(wd_cycles * 40);
		$display("Timeout: the tests did not finish in time");
		$display("SIMULATION FAILED");
		$fatal(1);
	end

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic abort(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	// Whole map, 32 pages at a time
	task automatic check_rom_map;
		for (int k = 0; k < 8; k++)
			compare("rom map", map_model[k*32 +: 32], rom_map[k*32 +: 32]);
	endtask

	function automatic logic [7:0] hex_char(input logic [3:0] n);
		hex_char = (n < 4'd10) ? 8'h30 + n : 8'h41 + n - 8'd10;
	endfunction

	function automatic logic [8:0] sys_page(input logic [1:0] seg);
		case (seg)
			2'd0: sys_page = 9'h000;
			2'd1: sys_page = 9'h100;
			2'd2: sys_page = 9'h107;
			default: sys_page = 9'h1ff;
		endcase
	endfunction

	////////////////////////////////////////
	// Host download

	task automatic start_file(input logic [7:0] idx, input logic [15:0] ext);
		@(posedge clk_sys);
		dl.download <= 1'b0;
		@(posedge clk_sys);
		dl.download <= 1'b1;
		dl.index    <= idx;
		dl.ext      <= ext;
		@(posedge clk_sys); // Page decoded here
	endtask

	// One byte, then every we pulse until dl_wait falls
	task automatic send_byte(input logic [24:0] addr, input logic [7:0] data,
			input int n_exp, input logic [22:0] exp_addr, input logic [1:0] bank0);
		int   seen;
		int   i;
		logic prev;
		begin
			seen = 0;
			i    = 0;
			prev = 1'b0;
			@(posedge clk_sys);
			dl.wr   <= 1'b1;
			dl.addr <= addr;
			dl.data <= data;
			@(posedge clk_sys);
			dl.wr <= 1'b0;
			while (i < 20 || dl_wait) begin
				@(negedge clk_sys);
				if (i == 0)
					compare("dl_wait after byte", n_exp != 0, dl_wait);
				if (ram_req.we && !prev) begin
					compare("boot addr", exp_addr, ram_req.addr);
					compare("boot bank", bank0 + seen, ram_req.bank);
					compare("boot data", data, ram_req.wdata);
					seen++;
				end
				prev = ram_req.we;
				i++;
				if (i > 64)
					abort("dl_wait stayed high after a download byte");
			end
			compare("boot write count", n_exp, seen);
		end
	endtask

	////////////////////////////////////////
	// CPU bus

	task automatic read_page(input logic [7:0] p, input logic exp_oe);
		@(posedge clk_sys);
		r = $random(seed);
		cpu.mem_rd   <= 1'b1;
		cpu.mem_addr <= {1'b1, p, r[13:0]};
		ram_dout     <= r[31:24];
		@(posedge clk_sys); // Mask page registered
		@(negedge clk_sys);
		compare("rom mask oe", exp_oe, ram_req.oe);
		compare("cpu ram addr", {1'b1, p, r[13:0]}, ram_req.addr);
		compare("cpu ram bank", 2'b01, ram_req.bank); // Model latched in reset
		compare("cpu din from ram", r[31:24], cpu_din);
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		logic [12:0] sa;
		begin
			@(posedge clk_sys);
			cpu.io_wr <= 1'b1;
			cpu.addr  <= a;
			cpu.dout  <= d;
			@(posedge clk_sys);
			cpu.io_wr <= 1'b0;
			case (a[15:8])
				8'h7f: case (d[7:6])
					2'b00: sa = 13'h1fcf;
					2'b01: sa = pen_m[4] ? 13'h1fdf : {9'h1f9, pen_m[3:0]};
					2'b10: sa = 13'h1fef;
					default: sa = 13'h1fff;
				endcase
				8'hbc: sa = 13'h1cff;
				8'hbd: sa = {9'h1db, crtc_m};
				8'hf7: sa = 13'h17ff;
				8'hdf: sa = 13'h1aac;
				default: sa = '0;
			endcase
			if (sa != '0) begin
				mf2_model[sa] = d;
				written.push_back(sa);
			end
			if (a[15:8] == 8'h7f && d[7:6] == 2'b00)
				pen_m = d[4:0];
			if (a[15:8] == 8'hbc)
				crtc_m = d[3:0];
		end
	endtask

	task automatic mem_write(input logic [12:0] off, input logic [7:0] d);
		@(posedge clk_sys);
		cpu.addr     <= 16'h2000 | off;
		cpu.mem_addr <= {10'd0, off};
		cpu.dout     <= d;
		cpu.mem_wr   <= 1'b1;
		@(negedge clk_sys);
		compare("mf2 ram write suppressed", 0, ram_req.we);
		@(posedge clk_sys);
		cpu.mem_wr <= 1'b0;
		mf2_model[off] = d;
		written.push_back(off);
	endtask

	task automatic m1_fetch(input logic [15:0] a);
		@(posedge clk_sys);
		cpu.addr <= a;
		cpu.m1   <= 1'b1;
		@(posedge clk_sys);
		cpu.m1 <= 1'b0;
		@(negedge clk_sys);
	endtask

	initial begin
		logic [13:0] off;
		logic [2:0]  seg;
		logic [3:0]  hi;
		logic [3:0]  lo;
		logic [8:0]  page;
		logic        bad;
		int          i;

		reset     = 1'b1;
		dl        = '0;
		cpu       = '0;
		cpu.addr  = 16'hc000;
		key_nmi   = 1'b0;
		mode      = mode_enabled;
		model_sel = 1'b1;
		ram_dout  = 8'hff;
		repeat (4) @(posedge clk_sys);

		// System ROM, segments 0..7 then one past the end
		start_file(8'd0, 16'h2020);
		for (i = 0; i < n_sys; i++) begin
			r    = $random(seed);
			off  = r[13:0];
			seg  = r[16:14];
			page = sys_page(seg[1:0]);
			send_byte({8'd0, seg, off}, r[31:24], 1, {page, off}, {1'b0, seg[2]});
			if (page[8])
				map_model[page[7:0]] = 1'b1; // Upper ROM slots count as loaded
		end
		send_byte(25'h20000 | off, 8'h5a, 0, '0, 2'd0);
		check_rom_map();

		// Expansion ROMs, loaded by hand so both banks
		for (int f = 0; f < n_files; f++) begin
			r   = $random(seed);
			hi  = (f == 0) ? 4'hf : r[3:0];
			lo  = (f == 0) ? 4'hf : r[7:4];
			bad = (f == n_files - 1);
			page = bad ? 9'h1ee : {1'b1, hi, lo};
			start_file(8'd1, bad ? "XQ" : {hex_char(hi), hex_char(lo)});
			for (i = 0; i < n_file_bytes; i++) begin
				r = $random(seed);
				send_byte({11'd0, r[13:0]}, r[23:16], 2, {page, r[13:0]}, 2'd0);
			end
			map_model[page[7:0]] = 1'b1;
			loaded.push_back(page[7:0]);
			check_rom_map();
		end

		@(posedge clk_sys);
		dl.download <= 1'b0;
		@(posedge clk_sys);
		reset     <= 1'b0;
		model_sel <= 1'b0;

		////////////////////////////////////////
		// ROM mask

		foreach (loaded[k])
			read_page(loaded[k], 1'b1);
		for (i = 0; i < 16; i++) begin
			r = $random(seed);
			read_page(r[7:0], map_model[r[7:0]]);
		end
		@(posedge clk_sys);
		mode <= mode_disabled;
		read_page(8'hff, 1'b0); // Page FF is loaded but masked
		@(posedge clk_sys);
		mode       <= mode_enabled;
		cpu.mem_rd <= 1'b0;

		////////////////////////////////////////
		// Multiface entry

		@(posedge clk_sys);
		mode    <= mode_disabled;
		key_nmi <= 1'b1;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		compare("nmi while disabled", 0, nmi);
		@(posedge clk_sys);
		key_nmi <= 1'b0;
		mode    <= mode_enabled;
		@(posedge clk_sys);
		key_nmi <= 1'b1;
		i = 0;
		while (!nmi) begin
			@(negedge clk_sys);
			i++;
			if (i > 8)
				abort("nmi did not rise after the NMI key");
		end
		@(posedge clk_sys);
		key_nmi <= 1'b0;
		m1_fetch(mf2_entry_addr);
		compare("nmi after entry", 0, nmi);
		compare("mf2 active after entry", 1, mf2_active);

		for (i = 0; i < 8; i++) begin
			r = $random(seed);
			@(posedge clk_sys);
			cpu.addr     <= {3'b000, r[12:0]};
			cpu.mem_addr <= {1'b0, r[29:8]};
			cpu.mem_rd   <= 1'b1;
			@(negedge clk_sys);
			compare("mf2 rom read oe", 1, ram_req.oe);
			compare("mf2 rom read addr", {9'h1ff, 1'b0, r[12:0]}, ram_req.addr);
			@(posedge clk_sys);
			cpu.mem_rd <= 1'b0;
			cpu.mem_wr <= 1'b1;
			@(negedge clk_sys);
			compare("mf2 rom write suppressed", 0, ram_req.we);
			@(posedge clk_sys);
			cpu.mem_wr <= 1'b0;
		end

		////////////////////////////////////////
		// Register shadow and Multiface RAM

		io_write(16'h7f00, 8'h05); // Pen select first
		io_write(16'hbc00, 8'h03);
		for (i = 0; i < n_mf2; i++) begin
			r = $random(seed);
			case (r[1:0])
				2'd0: io_write({8'h7f, r[15:8]}, r[23:16]);
				2'd1: io_write({7'h5e, r[2], r[15:8]}, r[23:16]); // BC or BD
				2'd2: io_write({8'hf7, r[15:8]}, r[23:16]);
				default: io_write({8'hdf, r[15:8]}, r[23:16]);
			endcase
			if (r[4])
				mem_write(r[28:16], r[31:24]);
		end
		foreach (written[k]) begin
			@(posedge clk_sys);
			cpu.addr     <= 16'h2000 | written[k];
			cpu.mem_addr <= {10'd0, written[k]};
			cpu.mem_rd   <= 1'b1;
			ram_dout     <= 8'hff;
			repeat (2) @(posedge clk_sys);
			@(negedge clk_sys);
			compare("mf2 ram read data", mf2_model[written[k]], cpu_din);
			compare("mf2 ram read oe", 0, ram_req.oe);
		end
		@(posedge clk_sys);
		cpu.mem_rd <= 1'b0;

		////////////////////////////////////////
		// Control port

		io_write(16'hfeea, 8'h00);
		@(negedge clk_sys);
		compare("disable by FEEA", 0, mf2_active);
		io_write(16'hfee8, 8'h00);
		@(negedge clk_sys);
		compare("enable by FEE8", 1, mf2_active);
		m1_fetch(mf2_hide_addr);
		io_write(16'hfeea, 8'h00);
		@(negedge clk_sys);
		compare("disable when hidden", 0, mf2_active);
		io_write(16'hfee8, 8'h00);
		@(negedge clk_sys);
		compare("no enable when hidden", 0, mf2_active);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- cpc_mem_glue.sv
/*
 * Memory-side glue of the CPC 6128 core. Connects the ROM loader, the
 * Multiface Two controller and RAM, and the external RAM arbiter between the
 * host download stream, the CPU bus and the external RAM port.
 */
module cpc_mem_glue (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  cpc_pkg::dl_stream_t           dl,
	output logic                          dl_wait,
	input  cpc_pkg::cpu_bus_t             cpu,
	input  logic                          key_nmi,
	input  cpc_pkg::mf2_mode_t            mode,
	input  logic                          model_sel,
	output cpc_pkg::ram_req_t             ram_req,
	input  logic [7:0]                    ram_dout,
	output logic [7:0]                    cpu_din,
	output logic [cpc_pkg::rom_map_w-1:0] rom_map,
	output logic                          nmi,
	output logic                          mf2_active
);
	import cpc_pkg::*;

	ram_req_t   boot_req;
	mf2_port_t  mf2_port;
	logic [7:0] mf2_rdata;
	logic       mf2_rom_en;
	logic       mf2_ram_en;

	cpc_rom_loader u_loader (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl       (dl),
		.dl_wait  (dl_wait),
		.boot_req (boot_req),
		.rom_map  (rom_map)
	);

	////////////////////////////////////////
	// Multiface Two

	cpc_mf2_ctrl u_mf2_ctrl (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.mode       (mode),
		.key_nmi    (key_nmi),
		.cpu        (cpu),
		.nmi        (nmi),
		.mf2_active (mf2_active),
		.mf2_rom_en (mf2_rom_en),
		.mf2_ram_en (mf2_ram_en),
		.port       (mf2_port)
	);

	cpc_mf2_ram u_mf2_ram (
		.clk_sys (clk_sys),
		.port    (mf2_port),
		.rdata   (mf2_rdata)
	);

	////////////////////////////////////////
	// External RAM

	cpc_mem_arbiter u_arbiter (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.boot_req   (boot_req),
		.cpu        (cpu),
		.rom_map    (rom_map),
		.model_sel  (model_sel),
		.mode       (mode),
		.mf2_rom_en (mf2_rom_en),
		.mf2_ram_en (mf2_ram_en),
		.mf2_rdata  (mf2_rdata),
		.ram_dout   (ram_dout),
		.ram_req    (ram_req),
		.cpu_din    (cpu_din)
	);

endmodule

//--- cpc_mem_arbiter.sv
/*
 * External RAM arbiter. The loader owns the RAM while reset is high, the CPU
 * otherwise. Reads of unloaded expansion ROM pages are masked and the
 * Multiface ROM and RAM take over the bottom 16 KiB when mapped in.
 */
module cpc_mem_arbiter (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  cpc_pkg::ram_req_t             boot_req,
	input  cpc_pkg::cpu_bus_t             cpu,
	input  logic [cpc_pkg::rom_map_w-1:0] rom_map,
	input  logic                          model_sel,
	input  cpc_pkg::mf2_mode_t            mode,
	input  logic                          mf2_rom_en,
	input  logic                          mf2_ram_en,
	input  logic [7:0]                    mf2_rdata,
	input  logic [7:0]                    ram_dout,
	output cpc_pkg::ram_req_t             ram_req,
	output logic [7:0]                    cpu_din
);
	import cpc_pkg::*;

	logic       model;
	logic [7:0] map_addr;
	logic       rom_mask;
	logic [7:0] mf2_dout;

	always_ff @(posedge clk_sys) begin
		if (reset)
			model <= model_sel; // Memory model taken while in reset
		map_addr <= cpu.mem_addr[21:14];
	end

	// Unloaded expansion page, or page FF with the Multiface disabled
	assign rom_mask = cpu.mem_addr[22]
		& (~rom_map[map_addr] | (&map_addr & (mode == mode_disabled)));

	always_comb begin
		if (reset) begin
			ram_req = boot_req;
		end else begin
			ram_req.oe    = cpu.mem_rd & ~mf2_ram_en & ~rom_mask;
			ram_req.we    = cpu.mem_wr & ~mf2_ram_en & ~mf2_rom_en;
			ram_req.addr  = mf2_rom_en ? {mf2_rom_page, cpu.addr[13:0]} : cpu.mem_addr;
			ram_req.bank  = {1'b0, model};
			ram_req.wdata = cpu.dout;
		end
	end

	assign mf2_dout = (mf2_ram_en & cpu.mem_rd) ? mf2_rdata : 8'hff;
	assign cpu_din  = ram_dout & mf2_dout; // Idle sources read as FF

endmodule

//--- cpc_mf2_ram.sv
/*
 * Multiface Two 8 KiB RAM. One registered port, written bytes show up on
 * the read data in the same clock as the write.
 */
module cpc_mf2_ram (
	input  logic               clk_sys,
	input  cpc_pkg::mf2_port_t port,
	output logic [7:0]         rdata
);
	import cpc_pkg::*;

	logic [7:0] mem [2**mf2_addr_w];

	always_ff @(posedge clk_sys) begin
		if (port.we) begin
			mem[port.addr] <= port.data;
			rdata          <= port.data; // Write-through
		end else begin
			rdata <= mem[port.addr];
		end
	end

endmodule

//--- cpc_mf2_ctrl.sv
/*
 * Multiface Two controller. Raises NMI from the button, maps its ROM and RAM
 * in at 0000-3FFF once the NMI vector is fetched, shadows writes to the
 * gate array, CRTC, PPI and ROM select, and drives the Multiface RAM port.
 */
module cpc_mf2_ctrl (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  cpc_pkg::mf2_mode_t   mode,
	input  logic                 key_nmi,
	input  cpc_pkg::cpu_bus_t    cpu,
	output logic                 nmi,
	output logic                 mf2_active,
	output logic                 mf2_rom_en,
	output logic                 mf2_ram_en,
	output cpc_pkg::mf2_port_t   port
);
	import cpc_pkg::*;

	logic                  mf2_en;
	logic                  hidden;
	logic                  old_key_nmi;
	logic                  old_m1;
	logic                  old_io_wr;
	logic                  m1_edge;
	logic                  io_edge;
	logic                  ctrl_hit;
	logic                  store_hit;
	logic [4:0]            pen_index;
	logic [3:0]            crtc_reg;
	logic [mf2_addr_w-1:0] store_addr;

	assign mf2_active = mf2_en;
	assign mf2_rom_en = mf2_en & (cpu.addr[15:13] == 3'b000);
	assign mf2_ram_en = mf2_en & (cpu.addr[15:13] == 3'b001);

	assign m1_edge   = cpu.m1 & ~old_m1;
	assign io_edge   = cpu.io_wr & ~old_io_wr;
	assign ctrl_hit  = io_edge & (cpu.addr[15:2] == mf2_ctrl_io[15:2]);
	assign store_hit = io_edge & ~ctrl_hit & (store_addr != '0);

	////////////////////////////////////////
	// Shadow address of a register write

	always_comb begin
		store_addr = '0;
		case (cpu.addr[15:8])
			8'h7f: begin // Gate array, function in the top data bits
				case (cpu.dout[7:6])
					2'b00: store_addr = mf2_sh_pen_sel;
					2'b01: store_addr = pen_index[4] ? mf2_sh_border
						: {mf2_sh_pen_base, pen_index[3:0]};
					2'b10: store_addr = mf2_sh_mode;
					default: store_addr = mf2_sh_bank;
				endcase
			end
			8'hbc: store_addr = mf2_sh_crtc_sel;
			8'hbd: store_addr = {mf2_sh_crtc_base, crtc_reg};
			8'hf7: store_addr = mf2_sh_ppi;
			8'hdf: store_addr = mf2_sh_rom_sel;
			default: store_addr = '0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		old_key_nmi <= key_nmi;
		old_m1      <= cpu.m1;
		old_io_wr   <= cpu.io_wr;

		if (reset) begin
			mf2_en <= 1'b0;
			hidden <= (mode != mode_enabled);
			nmi    <= 1'b0;
		end else begin
			if (key_nmi && !old_key_nmi && !mf2_en && mode != mode_disabled)
				nmi <= 1'b1;
			if (nmi && m1_edge && cpu.addr == mf2_entry_addr) begin
				mf2_en <= 1'b1; // Page in on the NMI fetch
				hidden <= 1'b0;
				nmi    <= 1'b0;
			end
			if (mf2_en && m1_edge && cpu.addr == mf2_hide_addr)
				hidden <= 1'b1;
			if (ctrl_hit)
				mf2_en <= ~cpu.addr[1] & ~hidden; // FEE8 on, FEEA off
		end
	end

	// Register indices used to place later shadow writes
	always_ff @(posedge clk_sys) begin
		if (store_hit) begin
			if (cpu.addr[15:8] == 8'h7f && cpu.dout[7:6] == 2'b00)
				pen_index <= cpu.dout[4:0];
			if (cpu.addr[15:8] == 8'hbc)
				crtc_reg <= cpu.dout[3:0];
		end
	end

	////////////////////////////////////////
	// RAM port, store then write then read

	always_ff @(posedge clk_sys) begin
		if (store_hit)
			port.addr <= store_addr;
		else
			port.addr <= cpu.mem_addr[mf2_addr_w-1:0];
		port.data <= cpu.dout;

		if (reset)
			port.we <= 1'b0;
		else
			port.we <= store_hit | (cpu.mem_wr & mf2_ram_en);
	end

endmodule

//--- cpc_rom_loader.sv
/*
 * ROM loader. Turns the host download stream into paced writes to external
 * RAM while the machine is held in reset. System ROMs go to fixed pages,
 * expansion ROMs to the page named by the file extension. dl_wait holds the
 * host off until every write of the current byte is done.
 */
module cpc_rom_loader (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  cpc_pkg::dl_stream_t        dl,
	output logic                       dl_wait,
	output cpc_pkg::ram_req_t          boot_req,
	output logic [cpc_pkg::rom_map_w-1:0] rom_map
);
	import cpc_pkg::*;

	logic [2:0]            div;
	logic                  ce_ref;
	logic                  old_download;
	logic                  dl_start;
	logic                  both_banks;
	logic [4:0]            hex_hi;
	logic [4:0]            hex_lo;

	logic                  boot_wr;
	logic [ram_addr_w-1:0] boot_addr;
	logic [1:0]            boot_bank;
	logic [7:0]            boot_data;

	// Kept across resets, the host holds reset during downloads
	logic [page_w-1:0]     page;
	logic                  combo;
	logic [rom_map_w-1:0]  map_q = '0;

	// Returns {valid, nibble} for an upper case hex character
	function automatic logic [4:0] hex_val(input logic [7:0] c);
		logic [7:0] d;
		begin
			d = c - 8'h30;
			if (c >= "0" && c <= "9")
				hex_val = {1'b1, d[3:0]};
			else if (c >= "A" && c <= "F")
				hex_val = {1'b1, c[3:0] + 4'd9};
			else
				hex_val = 5'd0;
		end
	endfunction

	assign dl_start   = dl.download & ~old_download;
	assign both_banks = (dl.index[7:6] == 2'b01) || (dl.index[5:0] != 6'd0); // Manual load
	assign hex_hi     = hex_val(dl.ext[15:8]);
	assign hex_lo     = hex_val(dl.ext[7:0]);

	// Reference enable, one clock in eight
	always_ff @(posedge clk_sys) begin
		if (reset && !dl.download) begin
			div    <= 3'd0;
			ce_ref <= 1'b0;
		end else begin
			div    <= div + 3'd1;
			ce_ref <= (div == 3'd0);
		end
	end

	always_ff @(posedge clk_sys) begin
		old_download <= dl.download;

		if (reset && !dl.download) begin
			dl_wait <= 1'b0;
			boot_wr <= 1'b0;
		end else begin
			// Byte accepted from the host
			if (dl.download && dl.wr) begin
				dl_wait         <= 1'b1;
				boot_data       <= dl.data;
				boot_addr[13:0] <= dl.addr[13:0];
				if (dl.index != 8'd0) begin
					boot_addr[22]    <= page[8];
					boot_addr[21:14] <= page[7:0] + dl.addr[21:14];
					boot_bank        <= {1'b0, &dl.index[7:6]};
				end else if (dl.addr[24:17] == 8'd0) begin
					boot_addr[22:14] <= sys_pages[dl.addr[15:14]];
					boot_bank        <= {1'b0, dl.addr[16]};
				end else begin
					dl_wait <= 1'b0; // Past segment 7, dropped
				end
			end

			if (ce_ref) begin
				boot_wr <= dl_wait;
				if (boot_wr && dl_wait) begin
					boot_wr <= 1'b0;
					if (both_banks && boot_bank == 2'd0) begin
						boot_bank <= 2'd1; // Same byte again for bank 1
					end else begin
						dl_wait <= 1'b0;
						if (boot_addr[22])
							map_q[boot_addr[21:14]] <= 1'b1;
						if (combo && &boot_addr[13:0]) begin
							combo <= 1'b0;
							page  <= mf2_rom_page; // Rest of a combo image
						end
					end
				end
			end
		end

		// Page decode from the extension at download start
		if (dl_start && dl.index != 8'd0) begin
			combo <= 1'b0;
			if (dl.ext == "ZZ") begin
				page <= '0;
			end else if (dl.ext == "Z0") begin
				page  <= '0;
				combo <= 1'b1;
			end else if (hex_hi[4] && hex_lo[4]) begin
				page <= {1'b1, hex_hi[3:0], hex_lo[3:0]};
			end else begin
				page <= bad_ext_page;
			end
		end
	end

	assign rom_map = map_q;

	always_comb begin
		boot_req.oe    = 1'b0; // Loader never reads
		boot_req.we    = boot_wr;
		boot_req.addr  = boot_addr;
		boot_req.bank  = boot_bank;
		boot_req.wdata = boot_data;
	end

endmodule

//--- cpc_pkg.sv
/*
 * Shared widths, address constants, bus structs and enums for the CPC
 * memory glue: ROM loader, Multiface Two and external RAM arbiter.
 * Modules import it inside their body and use scoped names in port lists.
 */
package cpc_pkg;

	////////////////////////////////////////
	// Widths

	localparam int ram_addr_w = 23;  // External RAM byte address
	localparam int page_w     = 9;   // 16 KiB page, top bit marks expansion ROM
	localparam int mf2_addr_w = 13;  // 8 KiB Multiface RAM
	localparam int dl_addr_w  = 25;
	localparam int rom_map_w  = 256; // One bit per expansion page

	////////////////////////////////////////
	// Pages and addresses

	localparam logic [page_w-1:0] mf2_rom_page = 9'h1ff;
	localparam logic [page_w-1:0] bad_ext_page = 9'h1ee;

	// System ROM segments 0..3, segments 4..7 reuse them in bank 1
	localparam logic [3:0][page_w-1:0] sys_pages = {9'h1ff, 9'h107, 9'h100, 9'h000};

	localparam logic [15:0] mf2_entry_addr = 16'h0066; // NMI vector
	localparam logic [15:0] mf2_hide_addr  = 16'h0065;
	localparam logic [15:0] mf2_ctrl_io    = 16'hfee8; // Bit 1 selects FEEA

	// Where hardware register writes are shadowed in Multiface RAM
	localparam logic [mf2_addr_w-1:0] mf2_sh_pen_sel  = 13'h1fcf;
	localparam logic [mf2_addr_w-1:0] mf2_sh_border   = 13'h1fdf;
	localparam logic [8:0]            mf2_sh_pen_base = 9'h1f9;  // + pen index
	localparam logic [mf2_addr_w-1:0] mf2_sh_mode     = 13'h1fef;
	localparam logic [mf2_addr_w-1:0] mf2_sh_bank     = 13'h1fff;
	localparam logic [mf2_addr_w-1:0] mf2_sh_crtc_sel = 13'h1cff;
	localparam logic [8:0]            mf2_sh_crtc_base = 9'h1db; // + CRTC register
	localparam logic [mf2_addr_w-1:0] mf2_sh_ppi      = 13'h17ff;
	localparam logic [mf2_addr_w-1:0] mf2_sh_rom_sel  = 13'h1aac;

	////////////////////////////////////////
	// Types

	typedef enum logic [1:0] {
		mode_enabled  = 2'd0,
		mode_hidden   = 2'd1,
		mode_disabled = 2'd2
	} mf2_mode_t;

	typedef struct packed {
		logic                 download; // Level for the whole file
		logic [7:0]           index;    // 0 is the system ROM
		logic [15:0]          ext;      // Last two extension characters
		logic                 wr;
		logic [dl_addr_w-1:0] addr;
		logic [7:0]           data;
	} dl_stream_t;

	typedef struct packed {
		logic [15:0]           addr;     // Z80 address
		logic [7:0]            dout;
		logic                  mem_rd;
		logic                  mem_wr;
		logic                  io_wr;
		logic                  m1;
		logic [ram_addr_w-1:0] mem_addr; // After the banking logic
	} cpu_bus_t;

	typedef struct packed {
		logic                  oe;
		logic                  we;
		logic [ram_addr_w-1:0] addr;
		logic [1:0]            bank;
		logic [7:0]            wdata;
	} ram_req_t;

	typedef struct packed {
		logic                  we;
		logic [mf2_addr_w-1:0] addr;
		logic [7:0]            data;
	} mf2_port_t;

endpackage
